//--- files.f
+incdir+include
hw/mac_pkg.sv
hw/mac_controller.sv
hw/weight_buffer.sv
hw/dotp_array.sv
hw/accumulator.sv
hw/requantizer.sv
hw/output_fifo.sv
hw/mac_top.sv
verification/mac_checker.sv
verification/tb_mac_top.sv

//--- hw/accumulator.sv
// ------------------------------
// Per-lane tile accumulation
// ------------------------------

`default_nettype none

`include "mac_cfg.svh"

module accumulator (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  mac_pkg::tile_flags_t flags_i,
  input  mac_pkg::oup_t        oup_i,
  input  mac_pkg::bias_t       bias_i,
  output mac_pkg::oup_t        result_o,
  output logic                 result_valid_o
);

  mac_pkg::oup_t acc_q;
  logic          valid_q;

  // Sums wrap at the accumulator width
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= flags_i.calc_en && flags_i.last_tile;
      if (flags_i.calc_en) begin
        for (int n = 0; n < `MAC_N; n++) begin
          if (flags_i.first_tile) begin
            acc_q[n] <= oup_i[n] + bias_i[n];
          end else begin
            acc_q[n] <= acc_q[n] + oup_i[n];
          end
        end
      end
    end
  end

  assign result_o       = acc_q;
  assign result_valid_o = valid_q;

endmodule

`default_nettype wire

//--- hw/dotp_array.sv
// ------------------------------
// N-lane signed dot products
// ------------------------------

`default_nettype none

`include "mac_cfg.svh"

module dotp_array (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             en_i,
  input  mac_pkg::inp_t    inp_i,
  input  mac_pkg::weight_t wt_i,
  output mac_pkg::oup_t    oup_o
);

  mac_pkg::oup_t sum_d;

  always_comb begin
    logic signed [`MAC_BW-1:0] lane_sum;
    for (int n = 0; n < `MAC_N; n++) begin
      lane_sum = '0;
      for (int m = 0; m < `MAC_M; m++) begin
        lane_sum = lane_sum + $signed(inp_i[m]) * $signed(wt_i[n][m]);
      end
      sum_d[n] = lane_sum;
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      oup_o <= '0;
    end else if (en_i) begin
      oup_o <= sum_d;
    end
  end

endmodule

`default_nettype wire

//--- hw/mac_controller.sv
// ------------------------------
// Tile sequencing, fire logic
// and output credit tracking
// ------------------------------

`default_nettype none

`include "mac_cfg.svh"

module mac_controller (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  mac_pkg::ctrl_t       ctrl_i,
  input  logic                 inp_valid_i,
  input  logic                 wt_valid_i,
  input  logic                 bias_valid_i,
  input  logic                 result_push_i,
  input  logic                 fifo_pop_i,
  input  mac_pkg::fifo_usage_t fifo_usage_i,
  output logic                 inp_ready_o,
  output logic                 wt_pop_o,
  output logic                 bias_ready_o,
  output mac_pkg::tile_flags_t flags_o,
  output logic                 busy_o
);

  mac_pkg::counter_t    tile_q;
  mac_pkg::counter_t    last_idx;
  mac_pkg::fifo_usage_t in_flight_q;

  logic [$bits(mac_pkg::fifo_usage_t):0] credits;

  logic first_tile;
  logic last_tile;
  logic credit_ok;
  logic fire;
  logic drained;
  logic busy_q;

  assign last_idx   = ctrl_i.inner_tiles - 1'b1;
  assign first_tile = (tile_q == '0);
  assign last_tile  = (tile_q == last_idx);

  // Vectors in the pipeline plus vectors waiting in the FIFO
  assign credits   = in_flight_q + fifo_usage_i;
  assign credit_ok = (credits < `MAC_FIFO_DEPTH);

  // Bias and a credit are only needed to open a new vector
  assign fire = inp_valid_i && wt_valid_i &&
                (!first_tile || (bias_valid_i && credit_ok));

  assign inp_ready_o  = fire;
  assign wt_pop_o     = fire;
  assign bias_ready_o = fire && first_tile;

  assign flags_o.calc_en    = fire;
  assign flags_o.first_tile = first_tile;
  assign flags_o.last_tile  = last_tile;

  // Last entry leaves the FIFO and nothing else is pending
  assign drained = (in_flight_q == '0) &&
                   ((fifo_usage_i == '0) || ((fifo_usage_i == 1) && fifo_pop_i));

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      tile_q      <= '0;
      in_flight_q <= '0;
      busy_q      <= 1'b0;
    end else begin
      if (fire) begin
        tile_q <= last_tile ? '0 : tile_q + 1'b1;
      end
      case ({fire && first_tile, result_push_i})
        2'b10:   in_flight_q <= in_flight_q + 1'b1;
        2'b01:   in_flight_q <= in_flight_q - 1'b1;
        default: in_flight_q <= in_flight_q;
      endcase
      if (fire) begin
        busy_q <= 1'b1;
      end else if (drained) begin
        busy_q <= 1'b0;
      end
    end
  end

  assign busy_o = busy_q;

endmodule

`default_nettype wire

//--- hw/mac_pkg.sv
// ------------------------------
// Shared vector types, control
// word and pipeline flags
// ------------------------------

`default_nettype none

`include "mac_cfg.svh"

package mac_pkg;

  // M operand elements, one input vector
  typedef logic [`MAC_M-1:0][`MAC_WI-1:0] inp_t;

  // One row per output lane
  typedef inp_t [`MAC_N-1:0] weight_t;

  typedef logic [`MAC_N-1:0][`MAC_BW-1:0] bias_t;

  // Dot products and accumulated sums
  typedef logic [`MAC_N-1:0][`MAC_BW-1:0] oup_t;

  typedef logic [`MAC_N-1:0][`MAC_WI-1:0] requant_oup_t;

  typedef logic [`MAC_CNT_W-1:0] counter_t;

  // Holds 0 up to MAC_FIFO_DEPTH
  typedef logic [$clog2(`MAC_FIFO_DEPTH):0] fifo_usage_t;

  typedef struct packed {
    counter_t          inner_tiles;
    logic [7:0]        eps_mult;
    logic [4:0]        right_shift;
    logic signed [7:0] add;
  } ctrl_t;

  // Travels alongside the data down the pipeline
  typedef struct packed {
    logic calc_en;
    logic first_tile;
    logic last_tile;
  } tile_flags_t;

endpackage

`default_nettype wire

//--- hw/mac_top.sv
// ------------------------------
// Matrix-vector engine top
// ------------------------------

`default_nettype none

module mac_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  mac_pkg::ctrl_t        ctrl_i,
  input  logic                  inp_valid_i,
  output logic                  inp_ready_o,
  input  mac_pkg::inp_t         inp_i,
  input  logic                  inp_weight_valid_i,
  output logic                  inp_weight_ready_o,
  input  mac_pkg::weight_t      inp_weight_i,
  input  logic                  inp_bias_valid_i,
  output logic                  inp_bias_ready_o,
  input  mac_pkg::bias_t        inp_bias_i,
  output logic                  valid_o,
  input  logic                  ready_i,
  output logic                  busy_o,
  output mac_pkg::requant_oup_t oup_o
);

  mac_pkg::tile_flags_t  flags, flags_q0, flags_q1;
  mac_pkg::inp_t         inp_q0;
  mac_pkg::weight_t      wt, wt_q0;
  mac_pkg::bias_t        bias_q0, bias_q1;
  mac_pkg::oup_t         dotp, result;
  mac_pkg::requant_oup_t requant_oup, fifo_data;
  mac_pkg::fifo_usage_t  fifo_usage;

  logic wt_valid, wt_pop;
  logic result_valid, push, pop, fifo_empty;

  // Flag pipeline for cycles 0 and 1
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      flags_q0 <= '0;
      flags_q1 <= '0;
    end else begin
      flags_q0 <= flags;
      flags_q1 <= flags_q0;
    end
  end

  // Operands sampled at fire, bias follows the first tile
  always_ff @(posedge clk_i) begin
    if (flags.calc_en) begin
      inp_q0 <= inp_i;
      wt_q0  <= wt;
    end
    if (flags.calc_en && flags.first_tile) begin
      bias_q0 <= inp_bias_i;
    end
    if (flags_q0.calc_en && flags_q0.first_tile) begin
      bias_q1 <= bias_q0;
    end
  end

  assign valid_o = !fifo_empty;
  assign pop     = valid_o && ready_i;
  assign oup_o   = valid_o ? fifo_data : '0;

  mac_controller i_controller (
    .clk_i        (clk_i           ),
    .rst_ni       (rst_ni          ),
    .ctrl_i       (ctrl_i          ),
    .inp_valid_i  (inp_valid_i     ),
    .wt_valid_i   (wt_valid        ),
    .bias_valid_i (inp_bias_valid_i),
    .result_push_i(push            ),
    .fifo_pop_i   (pop             ),
    .fifo_usage_i (fifo_usage      ),
    .inp_ready_o  (inp_ready_o     ),
    .wt_pop_o     (wt_pop          ),
    .bias_ready_o (inp_bias_ready_o),
    .flags_o      (flags           ),
    .busy_o       (busy_o          )
  );

  weight_buffer i_weight_buffer (
    .clk_i             (clk_i             ),
    .rst_ni            (rst_ni            ),
    .inp_weight_valid_i(inp_weight_valid_i),
    .inp_weight_ready_o(inp_weight_ready_o),
    .inp_weight_i      (inp_weight_i      ),
    .pop_i             (wt_pop            ),
    .wt_valid_o        (wt_valid          ),
    .wt_o              (wt                )
  );

  dotp_array i_dotp_array (
    .clk_i (clk_i           ),
    .rst_ni(rst_ni          ),
    .en_i  (flags_q0.calc_en),
    .inp_i (inp_q0          ),
    .wt_i  (wt_q0           ),
    .oup_o (dotp            )
  );

  accumulator i_accumulator (
    .clk_i         (clk_i       ),
    .rst_ni        (rst_ni      ),
    .flags_i       (flags_q1    ),
    .oup_i         (dotp        ),
    .bias_i        (bias_q1     ),
    .result_o      (result      ),
    .result_valid_o(result_valid)
  );

  requantizer i_requantizer (
    .clk_i        (clk_i       ),
    .rst_ni       (rst_ni      ),
    .valid_i      (result_valid),
    .result_i     (result      ),
    .ctrl_i       (ctrl_i      ),
    .valid_o      (push        ),
    .requant_oup_o(requant_oup )
  );

  output_fifo i_output_fifo (
    .clk_i  (clk_i      ),
    .rst_ni (rst_ni     ),
    .push_i (push       ),
    .data_i (requant_oup),
    .pop_i  (pop        ),
    .data_o (fifo_data  ),
    .empty_o(fifo_empty ),
    .usage_o(fifo_usage )
  );

endmodule

`default_nettype wire

//--- hw/output_fifo.sv
// ------------------------------
// Output FIFO with usage count
// ------------------------------

`default_nettype none

`include "mac_cfg.svh"

module output_fifo (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  push_i,
  input  mac_pkg::requant_oup_t data_i,
  input  logic                  pop_i,
  output mac_pkg::requant_oup_t data_o,
  output logic                  empty_o,
  output mac_pkg::fifo_usage_t  usage_o
);

  localparam int Depth = `MAC_FIFO_DEPTH;
  localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;

  mac_pkg::requant_oup_t mem_q [Depth];

  logic [PtrW-1:0]      wr_ptr_q;
  logic [PtrW-1:0]      rd_ptr_q;
  mac_pkg::fifo_usage_t usage_q;

  // Overflow is ruled out by the credit check upstream
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   usage_q <= usage_q + 1'b1;
        2'b01:   usage_q <= usage_q - 1'b1;
        default: usage_q <= usage_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (usage_q == '0);
  assign usage_o = usage_q;

endmodule

`default_nettype wire

//--- hw/requantizer.sv
// ------------------------------
// Scale, shift, offset and
// saturate to 8 bits
// ------------------------------

`default_nettype none

`include "mac_cfg.svh"

module requantizer (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  valid_i,
  input  mac_pkg::oup_t         result_i,
  input  mac_pkg::ctrl_t        ctrl_i,
  output logic                  valid_o,
  output mac_pkg::requant_oup_t requant_oup_o
);

  // Sum times a 9-bit signed view of eps_mult
  localparam int ProdW = `MAC_BW + 9;

  function automatic logic [`MAC_WI-1:0] requant_lane(logic signed [`MAC_BW-1:0] val,
                                                     mac_pkg::ctrl_t ctrl);
    logic signed [ProdW-1:0] prod;
    logic signed [ProdW-1:0] shifted;
    logic signed [ProdW:0]   sum;
    prod    = val * $signed({1'b0, ctrl.eps_mult});
    shifted = prod >>> ctrl.right_shift;
    sum     = shifted + $signed(ctrl.add);
    if (sum > 127) begin
      return 8'h7f;
    end else if (sum < -128) begin
      return 8'h80;
    end
    return sum[`MAC_WI-1:0];
  endfunction

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o       <= 1'b0;
      requant_oup_o <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        for (int n = 0; n < `MAC_N; n++) begin
          requant_oup_o[n] <= requant_lane(result_i[n], ctrl_i);
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/weight_buffer.sv
// ------------------------------
// Two-slot ping-pong weight
// store with load handshake
// ------------------------------

`default_nettype none

module weight_buffer (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             inp_weight_valid_i,
  output logic             inp_weight_ready_o,
  input  mac_pkg::weight_t inp_weight_i,
  input  logic             pop_i,
  output logic             wt_valid_o,
  output mac_pkg::weight_t wt_o
);

  mac_pkg::weight_t slot_q [2];

  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic [1:0] count_d;
  logic       ready_q;
  logic       write;

  assign write = inp_weight_valid_i && ready_q;

  always_comb begin
    count_d = count_q;
    case ({write, pop_i})
      2'b10:   count_d = count_q + 1'b1;
      2'b01:   count_d = count_q - 1'b1;
      default: count_d = count_q;
    endcase
  end

  // Ready is registered, so it stays low in the first cycle after reset
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= '0;
      ready_q  <= 1'b0;
    end else begin
      if (write) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop_i) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q <= count_d;
      ready_q <= (count_d < 2'd2);
    end
  end

  always_ff @(posedge clk_i) begin
    if (write) begin
      slot_q[wr_ptr_q] <= inp_weight_i;
    end
  end

  assign inp_weight_ready_o = ready_q;
  assign wt_valid_o         = (count_q != '0);
  assign wt_o               = slot_q[rd_ptr_q];

endmodule

`default_nettype wire

//--- include/mac_cfg.svh
// ------------------------------
// Size and width macros of the
// matrix-vector engine
// ------------------------------

`ifndef MAC_CFG_SVH
`define MAC_CFG_SVH

// Output lanes (rows of a weight tile)
`define MAC_N 4
// Elements per input vector
`define MAC_M 8
// Operand width
`define MAC_WI 8
// Bias and accumulator width
`define MAC_BW 24
// Output FIFO entries
`define MAC_FIFO_DEPTH 4
// Inner-tile counter width
`define MAC_CNT_W 4

`endif

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for failure

rm -f sim.log &&
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_mac_top -f files.f -o sim_mac --Mdir obj_dir &&
{ ./obj_dir/sim_mac > sim.log 2>&1 || true; } &&
cat sim.log &&
! grep -q "Simulation finished: FAIL" sim.log &&
grep -q "Simulation finished: PASS" sim.log &&
echo "Run passed" ||
{ echo "Run failed"; exit 1; }

//--- verification/mac_checker.sv
// ------------------------------
// Reference model, expected
// queue and output comparison
// ------------------------------

`default_nettype none

`include "mac_cfg.svh"

module mac_checker (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  mac_pkg::ctrl_t        ctrl_i,
  input  logic                  inp_valid_i,
  input  logic                  inp_ready_i,
  input  mac_pkg::inp_t         inp_i,
  input  logic                  wt_valid_i,
  input  logic                  wt_ready_i,
  input  mac_pkg::weight_t      wt_i,
  input  logic                  bias_valid_i,
  input  logic                  bias_ready_i,
  input  mac_pkg::bias_t        bias_i,
  input  logic                  valid_i,
  input  logic                  ready_i,
  input  logic                  busy_i,
  input  mac_pkg::requant_oup_t oup_i,
  output int                    value_errors_o,
  output int                    other_errors_o,
  output int                    checked_o,
  output int                    pending_o,
  output logic                  wt_full_seen_o
);

  timeunit 1ns;
  timeprecision 1ps;

  mac_pkg::weight_t          wt_q [$];
  mac_pkg::requant_oup_t     exp_q [$];
  logic signed [`MAC_BW-1:0] acc [`MAC_N];

  int   tile          = 0;
  int   value_errors  = 0;
  int   other_errors  = 0;
  int   checked       = 0;
  int   pending       = 0;
  logic wt_full_seen  = 1'b0;
  logic reset_checked = 1'b0;

  assign value_errors_o = value_errors;
  assign other_errors_o = other_errors;
  assign checked_o      = checked;
  assign pending_o      = pending;
  assign wt_full_seen_o = wt_full_seen;

  function automatic logic signed [`MAC_BW-1:0] dot(mac_pkg::inp_t x, mac_pkg::inp_t w);
    int s;
    s = 0;
    for (int m = 0; m < `MAC_M; m++) begin
      s += int'($signed(x[m])) * int'($signed(w[m]));
    end
    return s[`MAC_BW-1:0];
  endfunction

  // Scale by eps_mult, truncating shift, offset, clip to 8 bits
  function automatic logic [7:0] requant(logic signed [`MAC_BW-1:0] s, mac_pkg::ctrl_t c);
    longint v;
    v = longint'(s) * longint'(c.eps_mult);
    v = v >>> c.right_shift;
    v = v + longint'($signed(c.add));
    if (v > 127) begin
      return 8'h7f;
    end
    if (v < -128) begin
      return 8'h80;
    end
    return 8'(v);
  endfunction

  task automatic take_tile();
    mac_pkg::weight_t      w;
    mac_pkg::requant_oup_t e;
    logic                  first;
    first = (tile == 0);
    if (first && !(bias_valid_i && bias_ready_i)) begin
      $display("First tile fired at %0d ns without taking a bias", $time);
      other_errors++;
    end
    if (wt_q.size() == 0) begin
      $display("Input fired at %0d ns with no weight tile loaded", $time);
      other_errors++;
      return;
    end
    w = wt_q.pop_front();
    for (int n = 0; n < `MAC_N; n++) begin
      acc[n] = (first ? $signed(bias_i[n]) : acc[n]) + dot(inp_i, w[n]);
    end
    if (tile == int'(ctrl_i.inner_tiles) - 1) begin
      for (int n = 0; n < `MAC_N; n++) begin
        e[n] = requant(acc[n], ctrl_i);
      end
      exp_q.push_back(e);
      tile = 0;
    end else begin
      tile++;
    end
  endtask

  always @(posedge clk_i) begin
    mac_pkg::requant_oup_t exp_v;
    if (!rst_ni) begin
      tile = 0;
      wt_q.delete();
      exp_q.delete();
    end else begin
      if (!reset_checked) begin
        reset_checked = 1'b1;
        if (valid_i || busy_i || bias_ready_i || inp_ready_i || wt_ready_i ||
            (oup_i != '0)) begin
          $display("Outputs not idle after reset: valid_o=%b busy_o=%b bias ready=%b",
                   valid_i, busy_i, bias_ready_i);
          $display("Outputs not idle after reset: input ready=%b weight ready=%b oup_o=%h",
                   inp_ready_i, wt_ready_i, oup_i);
          other_errors++;
        end
      end
      if (!valid_i && (oup_i != '0)) begin
        $display("** Error at %0d ns: oup_o expected %h, got %h", $time, 32'h0, oup_i);
        value_errors++;
      end
      if (valid_i && ready_i) begin
        if (exp_q.size() == 0) begin
          $display("Output transfer at %0d ns with no vector expected", $time);
          other_errors++;
        end else begin
          exp_v = exp_q.pop_front();
          checked++;
          if (oup_i !== exp_v) begin
            $display("** Error at %0d ns: oup_o expected %h, got %h", $time, exp_v, oup_i);
            value_errors++;
          end
        end
      end
      if (wt_q.size() == 2 && !wt_ready_i) begin
        wt_full_seen = 1'b1;
      end
      if (bias_valid_i && bias_ready_i && !(inp_valid_i && inp_ready_i)) begin
        $display("Bias taken at %0d ns without an input transfer", $time);
        other_errors++;
      end
      if (inp_valid_i && inp_ready_i) begin
        take_tile();
      end
      if (wt_valid_i && wt_ready_i) begin
        if (wt_q.size() >= 2) begin
          $display("Weight tile accepted at %0d ns with both slots full", $time);
          other_errors++;
        end
        wt_q.push_back(wt_i);
      end
      pending = exp_q.size();
    end
  end

endmodule

`default_nettype wire

//--- verification/tb_mac_top.sv
// ------------------------------
// Testbench top: clock, reset,
// stimulus, watchdog and DUT
// ------------------------------

`default_nettype none

`include "mac_cfg.svh"

module tb_mac_top;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumJobs        = 12;
  localparam int MaxVectors     = 9;
  localparam int WatchdogCycles = 200 * NumJobs * MaxVectors + 1000;
  localparam int Wi             = `MAC_WI;
  localparam int Bw             = `MAC_BW;

  logic                  clk_i;
  logic                  rst_ni;
  mac_pkg::ctrl_t        ctrl_i;
  logic                  inp_valid_i;
  logic                  inp_ready_o;
  mac_pkg::inp_t         inp_i;
  logic                  inp_weight_valid_i;
  logic                  inp_weight_ready_o;
  mac_pkg::weight_t      inp_weight_i;
  logic                  inp_bias_valid_i;
  logic                  inp_bias_ready_o;
  mac_pkg::bias_t        inp_bias_i;
  logic                  valid_o;
  logic                  ready_i;
  logic                  busy_o;
  mac_pkg::requant_oup_t oup_o;

  int   value_errors;
  int   other_errors;
  int   checked;
  int   pending;
  logic wt_full_seen;
  int   tb_errors;

  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
  logic [15:0] lfsr_q;

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hb400) : (lfsr_q >> 1);
    end
    return val;
  endfunction

  function automatic mac_pkg::inp_t rand_vector();
    mac_pkg::inp_t v;
    for (int m = 0; m < `MAC_M; m++) begin
      v[m] = Wi'(rand_bits(Wi));
    end
    return v;
  endfunction

  function automatic mac_pkg::weight_t rand_weight();
    mac_pkg::weight_t w;
    for (int n = 0; n < `MAC_N; n++) begin
      w[n] = rand_vector();
    end
    return w;
  endfunction

  // Bias kept to 16 significant bits
  function automatic mac_pkg::bias_t rand_bias();
    mac_pkg::bias_t b;
    for (int n = 0; n < `MAC_N; n++) begin
      b[n] = Bw'($signed(16'(rand_bits(16))));
    end
    return b;
  endfunction

  function automatic mac_pkg::ctrl_t rand_ctrl(int job);
    mac_pkg::ctrl_t c;
    c.inner_tiles = (job == 0) ? 4'd1 : mac_pkg::counter_t'(2 + rand_bits(4) % 14);
    c.add         = 8'(rand_bits(8));
    if (job % 3 == 2) begin
      // Large gain with a small shift, lanes clip
      c.eps_mult    = {2'b11, 6'(rand_bits(6))};
      c.right_shift = 5'(rand_bits(2));
    end else begin
      c.eps_mult    = 8'(rand_bits(8));
      c.right_shift = 5'(10 + rand_bits(4));
    end
    return c;
  endfunction

  task automatic send_inputs(int count);
    for (int i = 0; i < count; i++) begin
      while (rand_bits(2) == 0) begin
        @(negedge clk_i);
      end
      inp_i       = rand_vector();
      inp_valid_i = 1'b1;
      do begin
        @(posedge clk_i);
      end while (!inp_ready_o);
      @(negedge clk_i);
      inp_valid_i = 1'b0;
    end
  endtask

  task automatic send_weights(int count);
    for (int i = 0; i < count; i++) begin
      while (rand_bits(2) == 0) begin
        @(negedge clk_i);
      end
      inp_weight_i       = rand_weight();
      inp_weight_valid_i = 1'b1;
      do begin
        @(posedge clk_i);
      end while (!inp_weight_ready_o);
      @(negedge clk_i);
      inp_weight_valid_i = 1'b0;
    end
  endtask

  task automatic send_biases(int count);
    for (int i = 0; i < count; i++) begin
      while (rand_bits(2) == 0) begin
        @(negedge clk_i);
      end
      inp_bias_i       = rand_bias();
      inp_bias_valid_i = 1'b1;
      do begin
        @(posedge clk_i);
      end while (!inp_bias_ready_o);
      @(negedge clk_i);
      inp_bias_valid_i = 1'b0;
    end
  endtask

  // Inputs wait until both weight slots are loaded
  task automatic wait_weights_full();
    int waited;
    waited = 0;
    while (inp_weight_ready_o && waited < 40) begin
      @(negedge clk_i);
      waited++;
    end
    if (inp_weight_ready_o) begin
      $display("Weight buffer never filled while inputs were held back");
      tb_errors++;
    end
  endtask

  always #10 clk_i = ~clk_i;

  always @(negedge clk_i) begin
    ready_i = (rand_bits(2) != 0);
  end

  initial begin
    int vectors;
    clk_i              = 1'b0;
    rst_ni             = 1'b0;
    lfsr_q             = 16'd15527;
    tb_errors          = 0;
    ctrl_i             = '0;
    inp_valid_i        = 1'b0;
    inp_i              = '0;
    inp_weight_valid_i = 1'b0;
    inp_weight_i       = '0;
    inp_bias_valid_i   = 1'b0;
    inp_bias_i         = '0;
    ready_i            = 1'b0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (2) @(negedge clk_i);
    for (int job = 0; job < NumJobs; job++) begin
      while (busy_o) begin
        @(negedge clk_i);
      end
      ctrl_i  = rand_ctrl(job);
      vectors = 2 + int'(rand_bits(3));
      fork
        begin
          if (job == 0) begin
            wait_weights_full();
          end
          send_inputs(vectors * int'(ctrl_i.inner_tiles));
        end
        send_weights(vectors * int'(ctrl_i.inner_tiles));
        send_biases(vectors);
      join
    end
    while (busy_o) begin
      @(negedge clk_i);
    end
    repeat (4) @(negedge clk_i);
    if (pending != 0) begin
      $display("%0d expected vectors never came out of the DUT", pending);
      tb_errors++;
    end
    if (!wt_full_seen) begin
      $display("Weight buffer was never seen holding two tiles");
      tb_errors++;
    end
    $display("Checked %0d vectors: %0d value errors, %0d other errors",
             checked, value_errors, other_errors + tb_errors);
    if (value_errors + other_errors + tb_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the DUT stopped making progress",
             WatchdogCycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

  mac_top dut_i (
    .clk_i             (clk_i             ),
    .rst_ni            (rst_ni            ),
    .ctrl_i            (ctrl_i            ),
    .inp_valid_i       (inp_valid_i       ),
    .inp_ready_o       (inp_ready_o       ),
    .inp_i             (inp_i             ),
    .inp_weight_valid_i(inp_weight_valid_i),
    .inp_weight_ready_o(inp_weight_ready_o),
    .inp_weight_i      (inp_weight_i      ),
    .inp_bias_valid_i  (inp_bias_valid_i  ),
    .inp_bias_ready_o  (inp_bias_ready_o  ),
    .inp_bias_i        (inp_bias_i        ),
    .valid_o           (valid_o           ),
    .ready_i           (ready_i           ),
    .busy_o            (busy_o            ),
    .oup_o             (oup_o             )
  );

  mac_checker checker_i (
    .clk_i         (clk_i             ),
    .rst_ni        (rst_ni            ),
    .ctrl_i        (ctrl_i            ),
    .inp_valid_i   (inp_valid_i       ),
    .inp_ready_i   (inp_ready_o       ),
    .inp_i         (inp_i             ),
    .wt_valid_i    (inp_weight_valid_i),
    .wt_ready_i    (inp_weight_ready_o),
    .wt_i          (inp_weight_i      ),
    .bias_valid_i  (inp_bias_valid_i  ),
    .bias_ready_i  (inp_bias_ready_o  ),
    .bias_i        (inp_bias_i        ),
    .valid_i       (valid_o           ),
    .ready_i       (ready_i           ),
    .busy_i        (busy_o            ),
    .oup_i         (oup_o             ),
    .value_errors_o(value_errors      ),
    .other_errors_o(other_errors      ),
    .checked_o     (checked           ),
    .pending_o     (pending           ),
    .wt_full_seen_o(wt_full_seen      )
  );

endmodule

`default_nettype wire
